//--- common/regex_config.svh
`ifndef REGEX_CONFIG_SVH
`define REGEX_CONFIG_SVH

// Stream ID space with one state slot per ID in each matcher
`define REGEX_NUM_STREAMS 64
`define REGEX_STREAM_W 6

// Number of category matchers
`define REGEX_NUM_CAT 2

// Width of the per-category packet match counters
`define REGEX_COUNT_W 16

// Literal patterns with the first byte in bits 31:24
// Category 0 looks for "GET "
`define REGEX_PATTERN_0 32'h4745_5420
// Category 1 looks for "HTTP"
`define REGEX_PATTERN_1 32'h4854_5450

// Extra cycles allowed on top of the per-record budget
`define REGEX_TIMEOUT_MARGIN 100

`endif

//--- common/regex_pkg.sv
`default_nettype none

`include "regex_config.svh"

package regex_pkg;

  // One payload byte
  typedef logic [7:0] char_t;

  // Stream identifier carried with every byte
  typedef logic [`REGEX_STREAM_W-1:0] stream_id_t;

  // Matched prefix length of a four byte literal
  // Values 0 to 3 are held while 4 only exists as the accept condition
  typedef logic [2:0] dfa_state_t;

  // One bit per category matcher
  typedef logic [`REGEX_NUM_CAT-1:0] cat_mask_t;

  // Per-category count of matching packets
  typedef logic [`REGEX_COUNT_W-1:0] match_count_t;

endpackage

`default_nettype wire

//--- logic/stream_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "regex_config.svh"

module stream_tracker
  import regex_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire char_t      char_in,
  input  wire             char_vld,
  input  wire             sop,
  input  wire             eop,
  input  wire stream_id_t stream_id,
  input  wire cat_mask_t  cat_enable,
  output char_t           t_char,
  output logic            t_char_vld,
  output logic            t_load,
  output logic            t_new_stream,
  output logic            t_eop,
  output stream_id_t      t_stream,
  output cat_mask_t       t_enable
);

  // One bit per stream ID that is set once the stream has started a packet
  logic [`REGEX_NUM_STREAMS-1:0] known;

  // High between sop and eop of the current packet
  logic in_pkt;

  // Strobes and the stream bitmap
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      t_char_vld   <= 1'b0;
      t_load       <= 1'b0;
      t_new_stream <= 1'b0;
      t_eop        <= 1'b0;
      known        <= '0;
      in_pkt       <= 1'b0;
    end
    else
    begin
      t_char_vld <= char_vld;
      t_load     <= char_vld & sop;
      t_eop      <= char_vld & eop;
      // Matchers restore state 0 for a stream never seen since reset
      t_new_stream <= char_vld & sop & ~known[stream_id];
      if (char_vld && sop)
        known[stream_id] <= 1'b1;
      // Single byte packet opens and closes in the same cycle
      if (char_vld && sop)
        in_pkt <= ~eop;
      else if (char_vld && eop)
        in_pkt <= 1'b0;
    end
  end

  // Byte payload follows the valid strobe
  always_ff @(posedge clk)
  begin
    if (char_vld)
    begin
      t_char   <= char_in;
      t_stream <= stream_id;
    end
    // Enables only matter at the packet end, so hold them until the next eop
    if (char_vld && eop)
      t_enable <= cat_enable;
  end

  // Qualifiers only come with a valid byte
  a_qual_vld : assert property (@(posedge clk) disable iff (!rst_n)
    (sop || eop) |-> char_vld);

  // Packets on the input do not nest
  a_sop_closed : assert property (@(posedge clk) disable iff (!rst_n)
    (char_vld && sop) |-> !in_pkt);

  // An eop closes an open packet or the one its own sop opens
  a_eop_open : assert property (@(posedge clk) disable iff (!rst_n)
    (char_vld && eop) |-> (in_pkt || sop));

endmodule

`default_nettype wire

//--- matcher/dfa_core.sv
`timescale 1ns/1ps
`default_nettype none

module dfa_core
  import regex_pkg::*;
#(
  parameter logic [31:0] PATTERN = 32'h0
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire char_t      char_in,
  input  wire             char_vld,
  input  wire dfa_state_t state_in,
  input  wire             state_in_vld,
  output dfa_state_t      state_out,
  output logic            accept_out
);

  dfa_state_t cur_state;
  dfa_state_t next_state;

  // Byte idx of the literal
  // Idx 0 sits in the high bits
  function automatic char_t pat_byte(input logic [1:0] idx);
    return PATTERN[8 * (3 - int'(idx)) +: 8];
  endfunction

  // A restored state overrides the held one for the first byte
  assign cur_state = state_in_vld ? state_in : state_out;

  // A miss falls back to 1 only if the byte opens the literal
  always_comb
  begin
    if (char_in == pat_byte(cur_state[1:0]))
      next_state = cur_state + 3'd1;
    else if (char_in == pat_byte(2'd0))
      next_state = 3'd1;
    else
      next_state = 3'd0;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_out  <= '0;
      accept_out <= 1'b0;
    end
    else
    begin
      // Accept is a one cycle pulse per completed literal
      accept_out <= char_vld && (next_state == 3'd4);
      if (char_vld)
        state_out <= (next_state == 3'd4) ? 3'd0 : next_state;
      else if (state_in_vld)
        state_out <= state_in;
    end
  end

  // Held state stays a proper prefix length even when restored
  a_state_range : assert property (@(posedge clk) disable iff (!rst_n)
    state_out <= 3'd3);

endmodule

`default_nettype wire

//--- matcher/category_matcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "regex_config.svh"

module category_matcher
  import regex_pkg::*;
#(
  parameter logic [31:0] PATTERN = 32'h0
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire char_t      t_char,
  input  wire             t_char_vld,
  input  wire             t_load,
  input  wire             t_new_stream,
  input  wire             t_eop,
  input  wire stream_id_t t_stream,
  input  wire             enable,
  output logic            m_done,
  output logic            m_fired,
  output match_count_t    count
);

  // Saved DFA state per stream ID
  dfa_state_t state_mem [`REGEX_NUM_STREAMS];

  // Registered DFA inputs
  char_t      char_r;
  logic       char_vld_r;
  dfa_state_t state_in_r;
  logic       state_in_vld_r;

  // DFA outputs
  dfa_state_t state_out;
  logic       accept_out;

  // Packet end and its enable delayed to line up with the DFA pipeline
  logic eop_q1;
  logic eop_q2;
  logic eop_q3;
  logic en_q1;
  logic en_q2;
  logic en_q3;

  // Stream of the packet in flight for the state write-back
  stream_id_t cur_stream;

  // Set once the literal is seen anywhere in the packet
  logic spec_flag;

  logic       save_now;
  dfa_state_t load_state;

  // Enabled packet end commits its state
  assign save_now = eop_q3 & en_q3;

  // Next packet of the same stream may load while the previous one saves
  // Forward the outgoing state in that case
  always_comb
  begin
    if (t_new_stream)
      load_state = '0;
    else if (save_now && (cur_stream == t_stream))
      load_state = state_out;
    else
      load_state = state_mem[t_stream];
  end

  // Stage 1 control where the restored state goes in with the first byte
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_r     <= 1'b0;
      state_in_vld_r <= 1'b0;
      eop_q1         <= 1'b0;
      eop_q2         <= 1'b0;
      eop_q3         <= 1'b0;
    end
    else
    begin
      char_vld_r     <= t_char_vld;
      state_in_vld_r <= t_load;
      eop_q1         <= t_eop;
      eop_q2         <= eop_q1;
      eop_q3         <= eop_q2;
    end
  end

  // Payload side of the pipeline
  always_ff @(posedge clk)
  begin
    char_r     <= t_char;
    state_in_r <= load_state;
    en_q1      <= enable;
    en_q2      <= en_q1;
    en_q3      <= en_q2;
    if (t_load)
      cur_stream <= t_stream;
  end

  dfa_core #(
    .PATTERN      (PATTERN)
  ) u_dfa_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (char_r),
    .char_vld     (char_vld_r),
    .state_in     (state_in_r),
    .state_in_vld (state_in_vld_r),
    .state_out    (state_out),
    .accept_out   (accept_out)
  );

  // Flag, count and done strobe
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count     <= '0;
      spec_flag <= 1'b0;
      m_done    <= 1'b0;
    end
    else
    begin
      m_done <= eop_q3;
      if (eop_q3)
      begin
        if (en_q3)
          count <= count + match_count_t'(spec_flag);
        else
          spec_flag <= 1'b0;
      end
      // Fresh packet starts unmatched
      if (t_load)
        spec_flag <= 1'b0;
      if (accept_out)
        spec_flag <= 1'b1;
    end
  end

  // Reported flag and state write-back at the packet end
  always_ff @(posedge clk)
  begin
    if (eop_q3)
      m_fired <= en_q3 & spec_flag;
    if (save_now)
      state_mem[cur_stream] <= state_out;
  end

  // Counter must not roll over
  a_count_wrap : assert property (@(posedge clk) disable iff (!rst_n)
    (save_now && spec_flag) |-> (count != '1));

endmodule

`default_nettype wire

//--- logic/match_report.sv
`timescale 1ns/1ps
`default_nettype none

module match_report
  import regex_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire cat_mask_t  m_done,
  input  wire cat_mask_t  m_fired,
  input  wire stream_id_t t_stream,
  input  wire             t_load,
  output logic            result_vld,
  output stream_id_t      result_stream,
  output cat_mask_t       result_fired
);

  // The next packet can load before the current one reports
  // Two entries cover that overlap
  stream_id_t stream_fifo [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic       all_done;

  assign all_done = &m_done;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
      result_vld <= 1'b0;
    end
    else
    begin
      result_vld <= all_done;
      if (t_load)
        wr_ptr <= ~wr_ptr;
      // Reports leave in packet order
      if (all_done)
        rd_ptr <= ~rd_ptr;
    end
  end

  // Stream queue and report payload
  always_ff @(posedge clk)
  begin
    if (t_load)
      stream_fifo[wr_ptr] <= t_stream;
    if (all_done)
    begin
      result_stream <= stream_fifo[rd_ptr];
      result_fired  <= m_fired;
    end
  end

  // Matchers run in lockstep, so done bits never split
  a_done_together : assert property (@(posedge clk) disable iff (!rst_n)
    (|m_done) |-> (&m_done));

endmodule

`default_nettype wire

//--- logic/regex_scan_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "regex_config.svh"

module regex_scan_top
  import regex_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire char_t      char_in,
  input  wire             char_vld,
  input  wire             sop,
  input  wire             eop,
  input  wire stream_id_t stream_id,
  input  wire cat_mask_t  cat_enable,
  output wire             result_vld,
  output wire stream_id_t result_stream,
  output wire cat_mask_t  result_fired,
  output wire match_count_t count_0,
  output wire match_count_t count_1
);

  // Tracker to matchers
  wire char_t      t_char;
  wire             t_char_vld;
  wire             t_load;
  wire             t_new_stream;
  wire             t_eop;
  wire stream_id_t t_stream;
  wire cat_mask_t  t_enable;

  // Matchers to report with one bit per category
  wire cat_mask_t  m_done;
  wire cat_mask_t  m_fired;

  stream_tracker u_stream_tracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (char_in),
    .char_vld     (char_vld),
    .sop          (sop),
    .eop          (eop),
    .stream_id    (stream_id),
    .cat_enable   (cat_enable),
    .t_char       (t_char),
    .t_char_vld   (t_char_vld),
    .t_load       (t_load),
    .t_new_stream (t_new_stream),
    .t_eop        (t_eop),
    .t_stream     (t_stream),
    .t_enable     (t_enable)
  );

  // Category 0 matches "GET "
  category_matcher #(
    .PATTERN      (`REGEX_PATTERN_0)
  ) u_matcher_0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .t_char       (t_char),
    .t_char_vld   (t_char_vld),
    .t_load       (t_load),
    .t_new_stream (t_new_stream),
    .t_eop        (t_eop),
    .t_stream     (t_stream),
    .enable       (t_enable[0]),
    .m_done       (m_done[0]),
    .m_fired      (m_fired[0]),
    .count        (count_0)
  );

  // Category 1 matches "HTTP"
  category_matcher #(
    .PATTERN      (`REGEX_PATTERN_1)
  ) u_matcher_1 (
    .clk          (clk),
    .rst_n        (rst_n),
    .t_char       (t_char),
    .t_char_vld   (t_char_vld),
    .t_load       (t_load),
    .t_new_stream (t_new_stream),
    .t_eop        (t_eop),
    .t_stream     (t_stream),
    .enable       (t_enable[1]),
    .m_done       (m_done[1]),
    .m_fired      (m_fired[1]),
    .count        (count_1)
  );

  match_report u_match_report (
    .clk           (clk),
    .rst_n         (rst_n),
    .m_done        (m_done),
    .m_fired       (m_fired),
    .t_stream      (t_stream),
    .t_load        (t_load),
    .result_vld    (result_vld),
    .result_stream (result_stream),
    .result_fired  (result_fired)
  );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 10
) (
  output logic clk
);

  // Free running clock that starts low for the first half period
  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- test/regex_scan_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "regex_config.svh"

module regex_scan_tb
  import regex_pkg::*;
();

  // Idle gap after each eop runs from 2 to MAX_GAP cycles
  localparam int MAX_GAP = 5;
  // Worst case cycles for one record
  localparam int REC_BUDGET = MAX_GAP + 1;
  // Cycles from the sampled eop byte to its result_vld strobe
  localparam int RESULT_LATENCY = 5;
  localparam logic [31:0] SEED = 32'hf182_3672;

  wire  clk;
  logic rst_n;

  // DUT inputs
  char_t      char_in;
  logic       char_vld;
  logic       sop;
  logic       eop;
  stream_id_t stream_id;
  cat_mask_t  cat_enable;

  // DUT outputs
  wire               result_vld;
  wire stream_id_t   result_stream;
  wire cat_mask_t    result_fired;
  wire match_count_t count_0;
  wire match_count_t count_1;

  // Byte records in file order
  logic       c_sop [$];
  logic       c_eop [$];
  stream_id_t c_stream [$];
  char_t      c_byte [$];
  cat_mask_t  c_en [$];

  // Expected reports in packet order
  stream_id_t   r_stream [$];
  cat_mask_t    r_fired [$];
  match_count_t r_count0 [$];
  match_count_t r_count1 [$];

  // Cycle in which each eop byte is sampled, oldest first
  int eop_cycle [$];

  integer seed;
  int     res_idx = 0;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;

  tb_clock #(
    .PERIOD_NS (10)
  ) u_tb_clock (
    .clk (clk)
  );

  regex_scan_top u_regex_scan_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .char_in       (char_in),
    .char_vld      (char_vld),
    .sop           (sop),
    .eop           (eop),
    .stream_id     (stream_id),
    .cat_enable    (cat_enable),
    .result_vld    (result_vld),
    .result_stream (result_stream),
    .result_fired  (result_fired),
    .count_0       (count_0),
    .count_1       (count_1)
  );

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_stream(input string name, input stream_id_t exp_val,
                              input stream_id_t act_val);
    if (act_val !== exp_val)
    begin
      $display("CHECK FAILED at %0d ns: %s expected %0h actual %0h",
               $time, name, exp_val, act_val);
      abort_run();
    end
  endtask

  task automatic check_fired(input string name, input cat_mask_t exp_val,
                             input cat_mask_t act_val);
    if (act_val !== exp_val)
    begin
      $display("CHECK FAILED at %0d ns: %s expected %0h actual %0h",
               $time, name, exp_val, act_val);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input match_count_t exp_val,
                             input match_count_t act_val);
    if (act_val !== exp_val)
    begin
      $display("CHECK FAILED at %0d ns: %s expected %0h actual %0h",
               $time, name, exp_val, act_val);
      abort_run();
    end
  endtask

  task automatic check_latency(input string name, input int exp_val,
                               input int act_val);
    if (act_val != exp_val)
    begin
      $display("CHECK FAILED at %0d ns: %s expected %0d actual %0d",
               $time, name, exp_val, act_val);
      abort_run();
    end
  endtask

  // Split the file into byte records and report records
  task automatic load_vectors();
    int          fd;
    string       line;
    logic [31:0] v_sop;
    logic [31:0] v_eop;
    logic [31:0] v_stream;
    logic [31:0] v_byte;
    logic [31:0] v_en;
    fd = $fopen("test/regex_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open test/regex_vectors.txt");
      abort_run();
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if ($sscanf(line, "C %h %h %h %h %h", v_sop, v_eop, v_stream, v_byte, v_en) == 5)
        begin
          c_sop.push_back(v_sop[0]);
          c_eop.push_back(v_eop[0]);
          c_stream.push_back(stream_id_t'(v_stream));
          c_byte.push_back(char_t'(v_byte));
          c_en.push_back(cat_mask_t'(v_en));
        end
        // Fields reused for the report columns
        else if ($sscanf(line, "R %h %h %h %h", v_stream, v_en, v_sop, v_eop) == 4)
        begin
          r_stream.push_back(stream_id_t'(v_stream));
          r_fired.push_back(cat_mask_t'(v_en));
          r_count0.push_back(match_count_t'(v_sop));
          r_count1.push_back(match_count_t'(v_eop));
        end
      end
      $fclose(fd);
      if (c_byte.size() == 0 || r_stream.size() == 0)
      begin
        $display("no byte or report records found in test/regex_vectors.txt");
        abort_run();
      end
    end
  endtask

  task automatic drive_idle();
    char_vld = 1'b0;
    sop      = 1'b0;
    eop      = 1'b0;
  endtask

  // One byte per cycle with a random idle gap after each packet
  task automatic drive_packets();
    int gap;
    for (int i = 0; i < c_byte.size(); i++)
    begin
      @(negedge clk);
      char_vld   = 1'b1;
      sop        = c_sop[i];
      eop        = c_eop[i];
      stream_id  = c_stream[i];
      char_in    = c_byte[i];
      cat_enable = c_en[i];
      if (c_eop[i])
      begin
        // The DUT samples this byte at the next rising edge
        eop_cycle.push_back(cycle_cnt + 1);
        gap = 2 + ($unsigned($random(seed)) % (MAX_GAP - 1));
        repeat (gap)
        begin
          @(negedge clk);
          drive_idle();
        end
      end
    end
    @(negedge clk);
    drive_idle();
  endtask

  // Compare each report while its strobe is high
  always @(negedge clk)
  begin
    if (rst_n && result_vld)
    begin
      if (res_idx >= r_stream.size() || eop_cycle.size() == 0)
      begin
        $display("report %0d arrived with no expected record or open packet left",
                 res_idx);
        abort_run();
      end
      else
      begin
        check_latency("result_vld latency", RESULT_LATENCY,
                      cycle_cnt - eop_cycle.pop_front());
        check_stream("result_stream", r_stream[res_idx], result_stream);
        check_fired("result_fired", r_fired[res_idx], result_fired);
        check_count("count_0", r_count0[res_idx], count_0);
        check_count("count_1", r_count1[res_idx], count_1);
        res_idx++;
      end
    end
  end

  // Watchdog on the total run length
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("timeout waiting for result");
      abort_run();
    end
  end

  initial
  begin
    rst_n      = 1'b0;
    char_in    = '0;
    char_vld   = 1'b0;
    sop        = 1'b0;
    eop        = 1'b0;
    stream_id  = '0;
    cat_enable = '0;
    seed       = SEED;
    load_vectors();
    cycle_limit = (c_byte.size() + r_stream.size()) * REC_BUDGET + `REGEX_TIMEOUT_MARGIN;
    // Reset held over three rising edges
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    drive_packets();
    while (res_idx < r_stream.size())
      @(negedge clk);
    // Give a stray extra report time to show up
    repeat (2 * REC_BUDGET) @(negedge clk);
    if (res_idx == r_stream.size())
    begin
      $display("TEST OK");
      $finish;
    end
    else
    begin
      $display("expected %0d reports but saw %0d", r_stream.size(), res_idx);
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/regex_pkg.sv
logic/stream_tracker.sv
matcher/dfa_core.sv
matcher/category_matcher.sv
logic/match_report.sv
logic/regex_scan_top.sv
test/tb_clock.sv
test/regex_scan_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= regex_scan_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Build and run, then decide the status from the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJ_DIR)

//--- test/regex_vectors.txt
# Byte records C sop eop stream byte enable_mask
# Report records R stream fired_mask count_0 count_1 in hex
C 1 0 01 47 3
C 0 0 01 45 3
C 0 0 01 54 3
C 0 1 01 20 3
R 01 1 0001 0000
C 1 0 02 48 3
C 0 1 02 54 3
R 02 0 0001 0000
C 1 0 03 54 3
C 0 1 03 50 3
R 03 0 0001 0000
C 1 1 02 54 3
R 02 0 0001 0000
C 1 1 02 50 1
R 02 0 0001 0000
C 1 1 02 50 3
R 02 2 0001 0001
C 1 0 04 47 3
C 0 0 04 47 3
C 0 0 04 45 3
C 0 0 04 54 3
C 0 0 04 20 3
C 0 0 04 47 3
C 0 0 04 45 3
C 0 0 04 54 3
C 0 1 04 20 3
R 04 1 0002 0001
